// File: all.f
+incdir+rtl
+incdir+tb
rtl/arcade_pkg.sv
rtl/host_input_decode.sv
rtl/cabinet_control.sv
rtl/host_output_glue.sv
rtl/arcade_shell.sv
tb/tb_arcade_shell.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_arcade_shell \
    -o sim_arcade_shell
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_arcade_shell)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// File: tb/tb_arcade_checks.svh
//////////////////////////////
// Concurrent checks of the shell outputs against the testbench models.
// One pass and one fail counter per check
//////////////////////////////

`ifndef TB_ARCADE_CHECKS_SVH
`define TB_ARCADE_CHECKS_SVH

    localparam int n_checks = 7;

    int pass_cnt [n_checks];
    int fail_cnt [n_checks];

    function automatic int total_fails();
        int sum;
        sum = 0;
        for (int i = 0; i < n_checks; i++) begin
            sum = sum + fail_cnt[i];
        end
        return sum;
    endfunction

    // Keys 3 cycles and joysticks 1 cycle back
    chk_cabinet: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        cabinet == cab_exp)
        pass_cnt[0] = pass_cnt[0] + 1;
    else begin
        fail_cnt[0] = fail_cnt[0] + 1;
        $display("ERR %s cabinet expected %h actual %h", test_name, cab_exp, cabinet);
    end

    chk_pause: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        system_pause == (pause_latch_m | (osd_status & pause_in_osd)))
        pass_cnt[1] = pass_cnt[1] + 1;
    else begin
        fail_cnt[1] = fail_cnt[1] + 1;
        $display("ERR %s pause expected %h actual %h", test_name,
                 pause_latch_m | (osd_status & pause_in_osd), system_pause);
    end

    chk_dip: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        dip_sw == ~{dip_m1, dip_m0})
        pass_cnt[2] = pass_cnt[2] + 1;
    else begin
        fail_cnt[2] = fail_cnt[2] + 1;
        $display("ERR %s dip expected %h actual %h", test_name, ~{dip_m1, dip_m0}, dip_sw);
    end

    chk_ch3: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        ch3 == ch3_exp)
        pass_cnt[3] = pass_cnt[3] + 1;
    else begin
        fail_cnt[3] = fail_cnt[3] + 1;
        $display("ERR %s ch3 expected %h actual %h", test_name, ch3_exp, ch3);
    end

    chk_rdy: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        rom_rdy == ch3_rdy && cpu_rdy == ch3_rdy)
        pass_cnt[4] = pass_cnt[4] + 1;
    else begin
        fail_cnt[4] = fail_cnt[4] + 1;
        $display("ERR %s rdy expected %b%b actual %b%b", test_name,
                 ch3_rdy, ch3_rdy, rom_rdy, cpu_rdy);
    end

    chk_aspect: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        {arx, ary} == aspect_exp)
        pass_cnt[5] = pass_cnt[5] + 1;
    else begin
        fail_cnt[5] = fail_cnt[5] + 1;
        $display("ERR %s aspect expected %h actual %h", test_name, aspect_exp, {arx, ary});
    end

    chk_vmode: assert property (@(posedge CLK_32M) disable iff (!rst_n)
        new_vmode == vmode_m)
        pass_cnt[6] = pass_cnt[6] + 1;
    else begin
        fail_cnt[6] = fail_cnt[6] + 1;
        $display("ERR %s vmode expected %b actual %b", test_name, vmode_m, new_vmode);
    end

`endif

// File: tb/tb_arcade_shell.sv
//////////////////////////////
// Testbench of the shell glue. Drives each behavior in turn.
// The included checks compare the outputs with small models
//////////////////////////////

`timescale 1ns/1ns
`include "arcade_macros.svh"

module tb_arcade_shell;

    localparam int run_cycles = 16 + 130 + 100 + 30 + 35 + 40 + 70;
    localparam int margin_cycles = 200;

    logic CLK_32M;
    logic rst_n;
    arcade_pkg::ps2_key_t ps2_key;
    logic [15:0] joystick_0;
    logic [15:0] joystick_1;
    logic osd_status;
    logic pause_in_osd;
    logic ioctl_download;
    logic ioctl_wr;
    logic [7:0] ioctl_index;
    logic [`IOCTL_ADDR_W-1:0] ioctl_addr;
    logic [7:0] ioctl_dout;
    arcade_pkg::sdr_req_t rom_req;
    arcade_pkg::sdr_req_t cpu_req;
    logic [1:0] cpu_wr_sel;
    logic ch3_rdy;
    logic [1:0] ar_mode;
    logic vertical;
    arcade_pkg::video_timing_e video_timing;
    arcade_pkg::cabinet_in_t cabinet;
    logic system_pause;
    logic [`DIP_OUT_BANKS-1:0][7:0] dip_sw;
    arcade_pkg::sdr_req_t ch3;
    logic rom_rdy;
    logic cpu_rdy;
    logic [`ASPECT_W-1:0] arx;
    logic [`ASPECT_W-1:0] ary;
    logic new_vmode;

    // Models
    arcade_pkg::key_buttons_t exp_keys;
    arcade_pkg::key_buttons_t keys_d1;
    arcade_pkg::key_buttons_t keys_d2;
    arcade_pkg::key_buttons_t keys_d3;
    logic [15:0] joy0_d1;
    logic [15:0] joy1_d1;
    arcade_pkg::cabinet_in_t cab_exp;
    logic pause_seen;
    logic pause_latch_m;
    logic [7:0] dip_m0;
    logic [7:0] dip_m1;
    arcade_pkg::sdr_req_t ch3_exp;
    logic [2*`ASPECT_W-1:0] aspect_exp;
    arcade_pkg::video_timing_e timing_m;
    logic vmode_m;
    integer seed;
    string test_name;

    arcade_shell dut (.*);

    function automatic arcade_pkg::key_buttons_t key_mask(input logic [7:0] code);
        arcade_pkg::key_buttons_t m;
        m = '0;
        case (code)
            8'h16: m.start1 = 1'b1;
            8'h1e: m.start2 = 1'b1;
            8'h2e: m.coin1 = 1'b1;
            8'h36: m.coin2 = 1'b1;
            8'h4d: m.pause = 1'b1;
            8'h75: m.up = 1'b1;
            8'h72: m.down = 1'b1;
            8'h6b: m.left = 1'b1;
            8'h74: m.right = 1'b1;
            8'h14: m.a = 1'b1;
            8'h11: m.b = 1'b1;
            8'h29: m.x = 1'b1;
            8'h12: m.y = 1'b1;
            default: m = '0;
        endcase
        return m;
    endfunction

    function automatic arcade_pkg::player_in_t player_bits(
        input arcade_pkg::key_buttons_t k,
        input logic [15:0] j
    );
        return ~{k.up | j[3], k.down | j[2], k.left | j[1], k.right | j[0],
                 k.a | j[4], k.b | j[5], k.x | j[6], k.y | j[7]};
    endfunction

    function automatic arcade_pkg::cabinet_in_t cabinet_from_inputs(
        input arcade_pkg::key_buttons_t k,
        input logic [15:0] j0,
        input logic [15:0] j1
    );
        arcade_pkg::cabinet_in_t c;
        c.spare = '1;
        c.p1 = player_bits(k, j0);
        c.p2 = player_bits(k, j1);
        c.start = ~{k.start2 | j0[10] | j1[10], k.start1 | j0[8] | j1[8]};
        c.coin = ~{k.coin2, k.coin1 | j0[9] | j1[9]};
        c.pause = k.pause | j0[11] | j1[11];
        return c;
    endfunction

    function automatic arcade_pkg::sdr_req_t route_channel(
        input logic dl,
        input logic [7:0] idx,
        input arcade_pkg::sdr_req_t rom,
        input arcade_pkg::sdr_req_t cpu,
        input logic [1:0] sel
    );
        arcade_pkg::sdr_req_t r;
        if (dl && idx == 8'd0) begin
            r = rom;
            r.rnw = 1'b0;
        end else begin
            r = cpu;
            r.be = sel;
            r.rnw = (sel == 2'b00);
        end
        return r;
    endfunction

    assign cab_exp = cabinet_from_inputs(keys_d3, joy0_d1, joy1_d1);
    assign ch3_exp = route_channel(ioctl_download, ioctl_index, rom_req, cpu_req, cpu_wr_sel);
    assign aspect_exp = (ar_mode == 2'd0) ?
        (vertical ? {12'd3, 12'd4} : {12'd4, 12'd3}) :
        {{10'd0, ar_mode} - 12'd1, 12'd0};

    always @(posedge CLK_32M) begin
        if (!rst_n) begin
            keys_d1 <= '0;
            keys_d2 <= '0;
            keys_d3 <= '0;
            joy0_d1 <= '0;
            joy1_d1 <= '0;
            pause_seen <= 1'b0;
            pause_latch_m <= 1'b0;
            dip_m0 <= '0;
            dip_m1 <= '0;
            timing_m <= arcade_pkg::vt_normal;
            vmode_m <= 1'b0;
        end else begin
            keys_d1 <= exp_keys;
            keys_d2 <= keys_d1;
            keys_d3 <= keys_d2;
            joy0_d1 <= joystick_0;
            joy1_d1 <= joystick_1;
            // Toggle on the rising edge of the merged pause level
            pause_seen <= cab_exp.pause;
            if (cab_exp.pause && !pause_seen) begin
                pause_latch_m <= ~pause_latch_m;
            end
            if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr == 25'd0) begin
                dip_m0 <= ioctl_dout;
            end
            if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr == 25'd1) begin
                dip_m1 <= ioctl_dout;
            end
            if (video_timing != timing_m) begin
                timing_m <= video_timing;
                vmode_m <= ~vmode_m;
            end
        end
    end

    `include "tb_arcade_checks.svh"

    initial begin
        CLK_32M = 1'b0;
        forever #4 CLK_32M = ~CLK_32M;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLK_32M);
    endtask

    task automatic send_key(input logic [7:0] code, input logic pressed);
        @(posedge CLK_32M);
        ps2_key <= '{toggle: ~ps2_key.toggle, pressed: pressed, extended: 1'b0, code: code};
        if (pressed) begin
            exp_keys <= exp_keys | key_mask(code);
        end else begin
            exp_keys <= exp_keys & ~key_mask(code);
        end
    endtask

    task automatic write_dip(input logic [7:0] idx, input int addr, input logic [7:0] data);
        @(posedge CLK_32M);
        ioctl_wr <= 1'b1;
        ioctl_index <= idx;
        ioctl_addr <= 25'(addr);
        ioctl_dout <= data;
        @(posedge CLK_32M);
        ioctl_wr <= 1'b0;
    endtask

    task automatic report(input string name, input int fails_before);
        $display("test %s done, %0d failures", name, total_fails() - fails_before);
    endtask

    task automatic press_each_key();
        arcade_pkg::key_code_e codes [13];
        int f0;
        codes = '{arcade_pkg::key_start1, arcade_pkg::key_start2, arcade_pkg::key_coin1,
                  arcade_pkg::key_coin2, arcade_pkg::key_pause, arcade_pkg::key_up,
                  arcade_pkg::key_down, arcade_pkg::key_left, arcade_pkg::key_right,
                  arcade_pkg::key_a, arcade_pkg::key_b, arcade_pkg::key_x, arcade_pkg::key_y};
        test_name = "key_map";
        f0 = total_fails();
        for (int i = 0; i < 13; i++) begin
            send_key(codes[i], 1'b1);
            wait_cycles(4);
            send_key(codes[i], 1'b0);
            wait_cycles(4);
        end
        // A key outside the cabinet set
        send_key(8'h5a, 1'b1);
        wait_cycles(4);
        send_key(8'h5a, 1'b0);
        wait_cycles(4);
        report("key_map", f0);
    endtask

    task automatic drive_random_joysticks();
        logic [31:0] r;
        int f0;
        test_name = "joystick";
        f0 = total_fails();
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            if (i == 20) begin
                send_key(8'h36, 1'b1);
            end
            @(posedge CLK_32M);
            joystick_0 <= r[15:0];
            joystick_1 <= r[31:16];
            wait_cycles(1);
        end
        send_key(8'h36, 1'b0);
        @(posedge CLK_32M);
        joystick_0 <= '0;
        joystick_1 <= '0;
        wait_cycles(4);
        report("joystick", f0);
    endtask

    task automatic load_dip_bytes();
        logic [31:0] r;
        int f0;
        test_name = "dip";
        f0 = total_fails();
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            write_dip(8'd254, 0, r[7:0]);
            write_dip(8'd254, 1, r[15:8]);
        end
        r = $random(seed);
        write_dip(8'd0, 0, r[7:0]);
        write_dip(8'd254, 2, r[15:8]);
        write_dip(8'd254, 8, r[23:16]);
        write_dip(8'd254, 9, r[31:24]);
        wait_cycles(2);
        report("dip", f0);
    endtask

    task automatic share_channel3();
        logic [31:0] r;
        logic [31:0] r2;
        int f0;
        test_name = "channel";
        f0 = total_fails();
        for (int i = 0; i < 30; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            @(posedge CLK_32M);
            rom_req <= {r[11:0], r2};
            cpu_req <= {r2[11:0], r};
            cpu_wr_sel <= r[13:12];
            ch3_rdy <= r[14];
            ioctl_download <= r[15];
            ioctl_index <= r[16] ? 8'd0 : 8'd5;
        end
        @(posedge CLK_32M);
        ioctl_download <= 1'b0;
        ch3_rdy <= 1'b0;
        wait_cycles(1);
        report("channel", f0);
    endtask

    task automatic sweep_aspect_vmode();
        arcade_pkg::video_timing_e seq [6];
        int f0;
        seq = '{arcade_pkg::vt_hz50, arcade_pkg::vt_hz50, arcade_pkg::vt_hz57,
                arcade_pkg::vt_normal, arcade_pkg::vt_normal, arcade_pkg::vt_hz60};
        test_name = "aspect_vmode";
        f0 = total_fails();
        for (int m = 0; m < 4; m++) begin
            for (int v = 0; v < 2; v++) begin
                @(posedge CLK_32M);
                ar_mode <= m[1:0];
                vertical <= v[0];
            end
        end
        for (int i = 0; i < 6; i++) begin
            @(posedge CLK_32M);
            video_timing <= seq[i];
            wait_cycles(3);
        end
        report("aspect_vmode", f0);
    endtask

    task automatic toggle_pause();
        int f0;
        test_name = "pause";
        f0 = total_fails();
        for (int i = 0; i < 2; i++) begin
            // Held key toggles once
            send_key(8'h4d, 1'b1);
            wait_cycles(8);
            send_key(8'h4d, 1'b0);
            wait_cycles(6);
        end
        @(posedge CLK_32M);
        joystick_1 <= 16'h0800;
        wait_cycles(5);
        joystick_1 <= '0;
        wait_cycles(5);
        // Menu part starts with the latch clear
        if (pause_latch_m) begin
            send_key(8'h4d, 1'b1);
            wait_cycles(4);
            send_key(8'h4d, 1'b0);
            wait_cycles(4);
        end
        osd_status <= 1'b1;
        pause_in_osd <= 1'b1;
        wait_cycles(3);
        pause_in_osd <= 1'b0;
        wait_cycles(3);
        osd_status <= 1'b0;
        wait_cycles(3);
        report("pause", f0);
    endtask

    // Watchdog
    initial begin
        #((run_cycles + margin_cycles) * 8);
        $display("watchdog timeout, tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int passes;
        int fails;
        seed = 32'h8e3b_896a;
        test_name = "startup";
        rst_n = 1'b0;
        ps2_key = '0;
        exp_keys = '0;
        joystick_0 = '0;
        joystick_1 = '0;
        osd_status = 1'b0;
        pause_in_osd = 1'b0;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_index = '0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        rom_req = '0;
        cpu_req = '0;
        cpu_wr_sel = '0;
        ch3_rdy = 1'b0;
        ar_mode = '0;
        vertical = 1'b0;
        video_timing = arcade_pkg::vt_normal;
        for (int i = 0; i < n_checks; i++) begin
            pass_cnt[i] = 0;
            fail_cnt[i] = 0;
        end
        wait_cycles(16);
        rst_n <= 1'b1;
        wait_cycles(2);
        press_each_key();
        drive_random_joysticks();
        load_dip_bytes();
        share_channel3();
        sweep_aspect_vmode();
        toggle_pause();
        passes = 0;
        fails = total_fails();
        for (int i = 0; i < n_checks; i++) begin
            passes = passes + pass_cnt[i];
            if (pass_cnt[i] == 0) begin
                $display("check %0d was never evaluated", i);
                fails = fails + 1;
            end
        end
        $display("checks passed %0d, failed %0d", passes, fails);
        if (fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/arcade_shell.sv
//////////////////////////////
// Top of the shell glue, joins input side, cabinet control
// and output side on the CLK_32M domain
//////////////////////////////

`timescale 1ns/1ns
`include "arcade_macros.svh"

module arcade_shell (
    input  logic                           CLK_32M,
    input  logic                           rst_n,
    // Host input
    input  arcade_pkg::ps2_key_t           ps2_key,
    input  logic [15:0]                    joystick_0,
    input  logic [15:0]                    joystick_1,
    input  logic                           osd_status,
    input  logic                           pause_in_osd,
    // Download port
    input  logic                           ioctl_download,
    input  logic                           ioctl_wr,
    input  logic [7:0]                     ioctl_index,
    input  logic [`IOCTL_ADDR_W-1:0]       ioctl_addr,
    input  logic [7:0]                     ioctl_dout,
    // SDRAM channel 3 sources
    input  arcade_pkg::sdr_req_t           rom_req,
    input  arcade_pkg::sdr_req_t           cpu_req,
    input  logic [1:0]                     cpu_wr_sel,
    input  logic                           ch3_rdy,
    // Video settings
    input  logic [1:0]                     ar_mode,
    input  logic                           vertical,
    input  arcade_pkg::video_timing_e      video_timing,
    // To core and host
    output arcade_pkg::cabinet_in_t        cabinet,
    output logic                           system_pause,
    output logic [`DIP_OUT_BANKS-1:0][7:0] dip_sw,
    output arcade_pkg::sdr_req_t           ch3,
    output logic                           rom_rdy,
    output logic                           cpu_rdy,
    output logic [`ASPECT_W-1:0]           arx,
    output logic [`ASPECT_W-1:0]           ary,
    output logic                           new_vmode
);

    arcade_pkg::key_buttons_t key_buttons;

    host_input_decode u_input (
        .CLK_32M     (CLK_32M),
        .rst_n       (rst_n),
        .ps2_key     (ps2_key),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .key_buttons (key_buttons),
        .dip_sw      (dip_sw)
    );

    cabinet_control u_cabinet (
        .CLK_32M      (CLK_32M),
        .rst_n        (rst_n),
        .key_buttons  (key_buttons),
        .joystick_0   (joystick_0),
        .joystick_1   (joystick_1),
        .osd_status   (osd_status),
        .pause_in_osd (pause_in_osd),
        .cabinet      (cabinet),
        .system_pause (system_pause)
    );

    host_output_glue u_output (
        .CLK_32M        (CLK_32M),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .rom_req        (rom_req),
        .cpu_req        (cpu_req),
        .cpu_wr_sel     (cpu_wr_sel),
        .ch3_rdy        (ch3_rdy),
        .ch3            (ch3),
        .rom_rdy        (rom_rdy),
        .cpu_rdy        (cpu_rdy),
        .ar_mode        (ar_mode),
        .vertical       (vertical),
        .video_timing   (video_timing),
        .arx            (arx),
        .ary            (ary),
        .new_vmode      (new_vmode)
    );

endmodule

// File: rtl/host_output_glue.sv
//////////////////////////////
// Output side of the shell. Shares SDRAM channel 3 between
// ROM download and CPU, picks the aspect ratio, flags mode changes
//////////////////////////////

`timescale 1ns/1ns
`include "arcade_macros.svh"

module host_output_glue (
    input  logic                      CLK_32M,
    input  logic                      rst_n,
    input  logic                      ioctl_download,
    input  logic [7:0]                ioctl_index,
    input  arcade_pkg::sdr_req_t      rom_req,
    input  arcade_pkg::sdr_req_t      cpu_req,
    input  logic [1:0]                cpu_wr_sel,
    input  logic                      ch3_rdy,
    output arcade_pkg::sdr_req_t      ch3,
    output logic                      rom_rdy,
    output logic                      cpu_rdy,
    input  logic [1:0]                ar_mode,
    input  logic                      vertical,
    input  arcade_pkg::video_timing_e video_timing,
    output logic [`ASPECT_W-1:0]      arx,
    output logic [`ASPECT_W-1:0]      ary,
    output logic                      new_vmode
);

    logic                      rom_write;
    arcade_pkg::video_timing_e timing_q;

    //////////////////////////////
    // SDRAM channel 3
    //////////////////////////////

    assign rom_write = ioctl_download && (ioctl_index == 8'(`ROM_INDEX));

    always_comb begin
        if (rom_write) begin
            ch3     = rom_req;
            ch3.rnw = 1'b0;
        end else begin
            ch3     = cpu_req;
            // Any byte lane selected means a write
            ch3.be  = cpu_wr_sel;
            ch3.rnw = ~|cpu_wr_sel;
        end
    end

    // Only one owner at a time, so both see the same ready pulse
    assign rom_rdy = ch3_rdy;
    assign cpu_rdy = ch3_rdy;

    //////////////////////////////
    // Aspect ratio
    //////////////////////////////

    always_comb begin
        if (ar_mode == 2'd0) begin
            arx = vertical ? `ASPECT_W'(`ASPECT_SHORT) : `ASPECT_W'(`ASPECT_LONG);
            ary = vertical ? `ASPECT_W'(`ASPECT_LONG) : `ASPECT_W'(`ASPECT_SHORT);
        end else begin
            // Full screen and the two user ratios
            arx = `ASPECT_W'(ar_mode) - `ASPECT_W'(1);
            ary = '0;
        end
    end

    // Host rescans the video mode whenever this flag flips
    always_ff @(posedge CLK_32M) begin
        if (!rst_n) begin
            timing_q  <= arcade_pkg::vt_normal;
            new_vmode <= 1'b0;
        end else if (video_timing != timing_q) begin
            timing_q  <= video_timing;
            new_vmode <= ~new_vmode;
        end
    end

    a_rom_write_only: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        rom_write |-> !ch3.rnw && (ch3.addr == rom_req.addr)
    );

endmodule

// File: rtl/cabinet_control.sv
//////////////////////////////
// Merges keyboard levels and both joysticks into the
// active-low cabinet inputs, and runs the pause toggle
//////////////////////////////

`timescale 1ns/1ns

module cabinet_control (
    input  logic                     CLK_32M,
    input  logic                     rst_n,
    input  arcade_pkg::key_buttons_t key_buttons,
    input  logic [15:0]              joystick_0,
    input  logic [15:0]              joystick_1,
    input  logic                     osd_status,
    input  logic                     pause_in_osd,
    output arcade_pkg::cabinet_in_t  cabinet,
    output logic                     system_pause
);

    localparam arcade_pkg::cabinet_in_t cab_released = '{
        spare: '1, p1: '1, p2: '1, start: '1, coin: '1, pause: 1'b0
    };

    logic [15:0]             joy;
    arcade_pkg::cabinet_in_t cab_d;
    logic                    pause_d;
    logic                    pause_latch;

    // Keyboard drives both players, joystick bits 3..0 are up, down, left, right
    function automatic arcade_pkg::player_in_t merge_player(
        input arcade_pkg::key_buttons_t keys,
        input logic [15:0]              js
    );
        arcade_pkg::player_in_t p;
        p.up    = ~(keys.up    | js[3]);
        p.down  = ~(keys.down  | js[2]);
        p.left  = ~(keys.left  | js[1]);
        p.right = ~(keys.right | js[0]);
        p.a     = ~(keys.a     | js[4]);
        p.b     = ~(keys.b     | js[5]);
        p.x     = ~(keys.x     | js[6]);
        p.y     = ~(keys.y     | js[7]);
        return p;
    endfunction

    assign joy = joystick_0 | joystick_1;

    always_comb begin
        cab_d          = cab_released;
        cab_d.p1       = merge_player(key_buttons, joystick_0);
        cab_d.p2       = merge_player(key_buttons, joystick_1);
        cab_d.start[0] = ~(key_buttons.start1 | joy[8]);
        cab_d.start[1] = ~(key_buttons.start2 | joy[10]);
        cab_d.coin[0]  = ~(key_buttons.coin1 | joy[9]);
        // No joystick coin for the second slot
        cab_d.coin[1]  = ~key_buttons.coin2;
        cab_d.pause    = key_buttons.pause | joy[11];
    end

    always_ff @(posedge CLK_32M) begin
        if (!rst_n) begin
            cabinet     <= cab_released;
            pause_d     <= 1'b0;
            pause_latch <= 1'b0;
        end else begin
            cabinet <= cab_d;
            pause_d <= cabinet.pause;
            if (cabinet.pause && !pause_d) begin
                pause_latch <= ~pause_latch;
            end
        end
    end

    // Menu open also holds the core when OSD pause is on
    assign system_pause = pause_latch | (osd_status & pause_in_osd);

    a_released_after_reset: assert property (
        @(posedge CLK_32M) $rose(rst_n) |-> (cabinet == cab_released) && !pause_latch
    );

endmodule

// File: rtl/host_input_decode.sv
//////////////////////////////
// Input side of the shell. Turns host PS/2 events into
// key levels and keeps the DIP bytes from the download port
//////////////////////////////

`timescale 1ns/1ns
`include "arcade_macros.svh"

module host_input_decode (
    input  logic                          CLK_32M,
    input  logic                          rst_n,
    input  arcade_pkg::ps2_key_t          ps2_key,
    input  logic                          ioctl_wr,
    input  logic [7:0]                    ioctl_index,
    input  logic [`IOCTL_ADDR_W-1:0]      ioctl_addr,
    input  logic [7:0]                    ioctl_dout,
    output arcade_pkg::key_buttons_t      key_buttons,
    output logic [`DIP_OUT_BANKS-1:0][7:0] dip_sw
);

    localparam int unsigned dip_sel_w = $clog2(`DIP_BANKS);

    arcade_pkg::ps2_key_t ps2_q;
    logic                 toggle_q;
    logic                 key_event;
    logic [7:0]           dip_mem [`DIP_BANKS];
    logic                 dip_wr;
    logic [dip_sel_w-1:0] dip_sel;

    //////////////////////////////
    // Keyboard
    //////////////////////////////

    // First stage holds the event, second compares its toggle
    assign key_event = ps2_q.toggle != toggle_q;

    always_ff @(posedge CLK_32M) begin
        ps2_q    <= ps2_key;
        toggle_q <= ps2_q.toggle;
        if (!rst_n) begin
            key_buttons <= '0;
        end else if (key_event) begin
            case (ps2_q.code)
                arcade_pkg::key_start1: key_buttons.start1 <= ps2_q.pressed;
                arcade_pkg::key_start2: key_buttons.start2 <= ps2_q.pressed;
                arcade_pkg::key_coin1:  key_buttons.coin1  <= ps2_q.pressed;
                arcade_pkg::key_coin2:  key_buttons.coin2  <= ps2_q.pressed;
                arcade_pkg::key_pause:  key_buttons.pause  <= ps2_q.pressed;
                arcade_pkg::key_up:     key_buttons.up     <= ps2_q.pressed;
                arcade_pkg::key_down:   key_buttons.down   <= ps2_q.pressed;
                arcade_pkg::key_left:   key_buttons.left   <= ps2_q.pressed;
                arcade_pkg::key_right:  key_buttons.right  <= ps2_q.pressed;
                arcade_pkg::key_a:      key_buttons.a      <= ps2_q.pressed;
                arcade_pkg::key_b:      key_buttons.b      <= ps2_q.pressed;
                arcade_pkg::key_x:      key_buttons.x      <= ps2_q.pressed;
                arcade_pkg::key_y:      key_buttons.y      <= ps2_q.pressed;
                // Other keys are not part of the cabinet
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // DIP switches
    //////////////////////////////

    assign dip_wr = ioctl_wr && (ioctl_index == 8'(`DIP_INDEX))
                    && (ioctl_addr < `IOCTL_ADDR_W'(`DIP_BANKS));
    assign dip_sel = ioctl_addr[dip_sel_w-1:0];

    always_ff @(posedge CLK_32M) begin
        if (!rst_n) begin
            dip_mem <= '{default: '0};
        end else if (dip_wr) begin
            dip_mem[dip_sel] <= ioctl_dout;
        end
    end

    // Core reads its switches active low
    for (genvar i = 0; i < `DIP_OUT_BANKS; i++) begin : g_dip_out
        assign dip_sw[i] = ~dip_mem[i];
    end

    // One PS/2 event carries one key
    a_one_key_per_cycle: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        $countones(key_buttons ^ $past(key_buttons)) <= 1
    );

endmodule

// File: rtl/arcade_pkg.sv
//////////////////////////////
// Types shared by the shell RTL and its testbench.
// Refer to them as arcade_pkg::name
//////////////////////////////

`include "arcade_macros.svh"

package arcade_pkg;

    // Host PS/2 event, toggle flips once per event
    typedef struct packed {
        logic       toggle;
        logic       pressed;
        logic       extended;
        logic [7:0] code;
    } ps2_key_t;

    // Set 2 scan codes of the cabinet keys
    typedef enum logic [7:0] {
        key_start1 = 8'h16,
        key_start2 = 8'h1e,
        key_coin1  = 8'h2e,
        key_coin2  = 8'h36,
        key_pause  = 8'h4d,
        key_up     = 8'h75,
        key_down   = 8'h72,
        key_left   = 8'h6b,
        key_right  = 8'h74,
        key_a      = 8'h14,
        key_b      = 8'h11,
        key_x      = 8'h29,
        key_y      = 8'h12
    } key_code_e;

    // Keyboard levels, active high
    typedef struct packed {
        logic start1;
        logic start2;
        logic coin1;
        logic coin2;
        logic pause;
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic x;
        logic y;
    } key_buttons_t;

    // One player, active low
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic x;
        logic y;
    } player_in_t;

    // Inputs to the core; spare lines stay released, pause is active high
    typedef struct packed {
        logic [2:0] spare;
        player_in_t p1;
        player_in_t p2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       pause;
    } cabinet_in_t;

    // SDRAM channel request, req is a level
    typedef struct packed {
        logic [`SDR_ADDR_W-1:0] addr;
        logic [`SDR_DATA_W-1:0] din;
        logic [1:0]             be;
        logic                   rnw;
        logic                   req;
    } sdr_req_t;

    typedef enum logic [1:0] {
        vt_normal = 2'd0,
        vt_hz50   = 2'd1,
        vt_hz57   = 2'd2,
        vt_hz60   = 2'd3
    } video_timing_e;

endpackage

// File: rtl/arcade_macros.svh
//////////////////////////////
// Shared widths, download indexes and aspect constants
// for the arcade shell glue. Include wherever a width is needed
//////////////////////////////

`ifndef ARCADE_MACROS_SVH
`define ARCADE_MACROS_SVH

// SDRAM channel 3 word address and data
`define SDR_ADDR_W      24
`define SDR_DATA_W      16

// DIP switch store, and how many bytes go to the core
`define DIP_BANKS       8
`define DIP_OUT_BANKS   2

// Download port
`define ROM_INDEX       0
`define DIP_INDEX       254
`define IOCTL_ADDR_W    25

// Aspect ratio values for the scaler
`define ASPECT_W        12
`define ASPECT_LONG     4
`define ASPECT_SHORT    3

`endif
